// File: Makefile
# Verilator build for the ALU processor testbench
# Override any variable on the command line, e.g. make sim TOP=tb_alu_processor

VERILATOR ?= verilator
TOP       ?= tb_alu_processor
SRC_LIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
SIM_BIN   ?= V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(SRC_LIST) --top-module $(TOP)

# A $fatal in the testbench makes the binary exit nonzero, which fails this target
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(SRC_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: logic/add_sub_unit.sv
`default_nettype none
`timescale 1ns/1ns

module add_sub_unit #(
    parameter int DATA_W = 8
) (
    input  alu_pkg::alu_op_e            op,
    input  logic [DATA_W-1:0]           a,
    input  logic [DATA_W-1:0]           b,
    output logic [DATA_W-1:0]           sum,
    output logic [alu_pkg::FLAGS_W-1:0] sum_flags
);
    import alu_pkg::*;

    logic              is_sub;              // Subtract selects inverted b and carry-in 1
    logic [DATA_W-1:0] b_eff;               // b or ~b

    assign is_sub = (op == OP_SUB);
    assign b_eff  = is_sub ? ~b : b;

    // One full-adder cell per bit
    for (genvar i = 0; i < DATA_W; i++) begin : g_fa
        logic carry_in;                     // Carry from the cell below
        logic half_sum;                     // a ^ b of this cell
        logic carry_out;

        if (i == 0) begin : g_first
            assign carry_in = is_sub;       // Two's complement +1
        end else begin : g_ripple
            assign carry_in = g_fa[i - 1].carry_out;
        end

        assign half_sum  = a[i] ^ b_eff[i];
        assign sum[i]    = half_sum ^ carry_in;
        assign carry_out = (a[i] & b_eff[i]) | (half_sum & carry_in);
    end

    assign sum_flags[FLAG_Z] = (sum == '0);
    assign sum_flags[FLAG_S] = sum[DATA_W-1];
    assign sum_flags[FLAG_C] = g_fa[DATA_W-1].carry_out;   // Set on subtract means a >= b

    // Same-sign adder inputs and a flipped result sign
    // On subtract b_eff holds the inverted sign of b and so gives the differing-signs rule
    assign sum_flags[FLAG_V] = (a[DATA_W-1] == b_eff[DATA_W-1])
                             && (sum[DATA_W-1] != a[DATA_W-1]);

endmodule

`default_nettype wire

// File: logic/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // Instruction opcodes as they arrive on the opcode port
    typedef enum logic [7:0] {
        OPC_ADD  = 8'd1,
        OPC_SUB  = 8'd2,
        OPC_MUL  = 8'd3,
        OPC_DIV  = 8'd4,
        OPC_MOD  = 8'd5,
        OPC_AND  = 8'd6,
        OPC_OR   = 8'd7,
        OPC_XOR  = 8'd8,
        OPC_NOT  = 8'd9,
        OPC_NOR  = 8'd10,
        OPC_NAND = 8'd11,
        OPC_XNOR = 8'd12
    } opcode_e;

    // Internal operation code carried down the pipeline
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,                     // Invalid opcode, result forced to zero
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_DIV,
        OP_MOD,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOT,                             // Unary, uses a only
        OP_NOR,
        OP_NAND,
        OP_XNOR
    } alu_op_e;

    localparam int FLAGS_W = 4;             // Z, S, C, V
    localparam int FLAG_Z  = 0;             // Result is zero
    localparam int FLAG_S  = 1;             // Top result bit
    localparam int FLAG_C  = 2;             // Carry out, or no borrow on subtract
    localparam int FLAG_V  = 3;             // Signed overflow

endpackage

`default_nettype wire

// File: logic/alu_processor.sv
`default_nettype none
`timescale 1ns/1ns

module alu_processor #(
    parameter int DATA_W = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [7:0]                  opcode,     // Stays 8 bits at any DATA_W
    input  logic [DATA_W-1:0]           operand_a,
    input  logic [DATA_W-1:0]           operand_b,
    output logic [DATA_W-1:0]           result,
    output logic [alu_pkg::FLAGS_W-1:0] flags
);
    import alu_pkg::*;

    alu_op_e            op;                 // Issued operation
    logic [DATA_W-1:0]  a;                  // Issued operands
    logic [DATA_W-1:0]  b;
    logic [DATA_W-1:0]  sum;
    logic [FLAGS_W-1:0] sum_flags;
    logic [DATA_W-1:0]  product;
    logic               product_carry;
    logic [DATA_W-1:0]  quotient;
    logic [DATA_W-1:0]  remainder;
    logic               divide_by_zero;
    logic [DATA_W-1:0]  bitwise_result;

    issue_stage #(.DATA_W(DATA_W)) issue0 (   // Stage 1, decode and capture
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op        (op),
        .a         (a),
        .b         (b)
    );

    add_sub_unit #(.DATA_W(DATA_W)) add_sub0 (
        .op        (op),
        .a         (a),
        .b         (b),
        .sum       (sum),
        .sum_flags (sum_flags)
    );

    shift_add_multiplier #(.DATA_W(DATA_W)) mul0 (
        .a             (a),
        .b             (b),
        .product       (product),
        .product_carry (product_carry)
    );

    restoring_divider #(.DATA_W(DATA_W)) div0 (   // Shared by DIV and MOD
        .a              (a),
        .b              (b),
        .quotient       (quotient),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero)
    );

    bitwise_unit #(.DATA_W(DATA_W)) logic0 (
        .op             (op),
        .a              (a),
        .b              (b),
        .bitwise_result (bitwise_result)
    );

    result_stage #(.DATA_W(DATA_W)) result0 ( // Stage 2, select and register
        .clk            (clk),
        .reset          (reset),
        .op             (op),
        .sum            (sum),
        .sum_flags      (sum_flags),
        .product        (product),
        .product_carry  (product_carry),
        .quotient       (quotient),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero),
        .bitwise_result (bitwise_result),
        .result         (result),
        .flags          (flags)
    );

endmodule

`default_nettype wire

// File: logic/bitwise_unit.sv
`default_nettype none
`timescale 1ns/1ns

module bitwise_unit #(
    parameter int DATA_W = 8
) (
    input  alu_pkg::alu_op_e  op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] bitwise_result
);
    import alu_pkg::*;

    always_comb begin
        case (op)
            OP_AND:  bitwise_result = a & b;
            OP_OR:   bitwise_result = a | b;
            OP_XOR:  bitwise_result = a ^ b;
            OP_NOT:  bitwise_result = ~a;           // b ignored
            OP_NOR:  bitwise_result = ~(a | b);
            OP_NAND: bitwise_result = ~(a & b);
            OP_XNOR: bitwise_result = ~(a ^ b);
            default: bitwise_result = '0;           // Arithmetic or invalid op
        endcase
    end

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
`default_nettype none
`timescale 1ns/1ns

module issue_stage #(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        opcode,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    output alu_pkg::alu_op_e  op,
    output logic [DATA_W-1:0] a,
    output logic [DATA_W-1:0] b
);
    import alu_pkg::*;

    alu_op_e op_dec;                        // Decoded opcode, before the register

    always_comb begin
        case (opcode)
            OPC_ADD:  op_dec = OP_ADD;
            OPC_SUB:  op_dec = OP_SUB;
            OPC_MUL:  op_dec = OP_MUL;
            OPC_DIV:  op_dec = OP_DIV;
            OPC_MOD:  op_dec = OP_MOD;
            OPC_AND:  op_dec = OP_AND;
            OPC_OR:   op_dec = OP_OR;
            OPC_XOR:  op_dec = OP_XOR;
            OPC_NOT:  op_dec = OP_NOT;
            OPC_NOR:  op_dec = OP_NOR;
            OPC_NAND: op_dec = OP_NAND;
            OPC_XNOR: op_dec = OP_XNOR;
            default:  op_dec = OP_NONE;     // Anything outside 1..12
        endcase
    end

    // Op and operands move together, one instruction per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op <= OP_NONE;
            a  <= '0;
            b  <= '0;
        end else begin
            op <= op_dec;
            a  <= operand_a;
            b  <= operand_b;
        end
    end

endmodule

`default_nettype wire

// File: logic/restoring_divider.sv
`default_nettype none
`timescale 1ns/1ns

module restoring_divider #(
    parameter int DATA_W = 8
) (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] quotient,
    output logic [DATA_W-1:0] remainder,
    output logic              divide_by_zero
);

    logic [DATA_W:0]   part;                // Partial remainder, one guard bit
    logic [DATA_W:0]   trial;               // part minus divisor
    logic [DATA_W-1:0] q;                   // Raw quotient bits

    // DATA_W restoring steps, dividend bits fed in from the top
    always_comb begin
        part  = '0;
        trial = '0;
        q     = '0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            part  = {part[DATA_W-1:0], a[i]};   // Bring down next bit
            trial = part - {1'b0, b};
            if (!trial[DATA_W]) begin           // No borrow, divisor fits
                part = trial;
                q[i] = 1'b1;
            end
            // Otherwise keep part as is, which is the restore
        end
    end

    assign divide_by_zero = (b == '0);

    // Zero divisor gives zero outputs instead of the all-ones quotient
    assign quotient  = divide_by_zero ? '0 : q;
    assign remainder = divide_by_zero ? '0 : part[DATA_W-1:0];

endmodule

`default_nettype wire

// File: logic/result_stage.sv
`default_nettype none
`timescale 1ns/1ns

module result_stage #(
    parameter int DATA_W = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    input  alu_pkg::alu_op_e            op,
    input  logic [DATA_W-1:0]           sum,
    input  logic [alu_pkg::FLAGS_W-1:0] sum_flags,
    input  logic [DATA_W-1:0]           product,
    input  logic                        product_carry,
    input  logic [DATA_W-1:0]           quotient,
    input  logic [DATA_W-1:0]           remainder,
    input  logic                        divide_by_zero,
    input  logic [DATA_W-1:0]           bitwise_result,
    output logic [DATA_W-1:0]           result,
    output logic [alu_pkg::FLAGS_W-1:0] flags
);
    import alu_pkg::*;

    logic [DATA_W-1:0]  result_next;        // Selected unit output
    logic [FLAGS_W-1:0] flags_next;
    logic               carry_next;         // C for mul, div and mod
    logic               is_add_sub;         // Flags come straight from the adder
    logic               op_valid;           // Low for OP_NONE

    always_comb begin
        result_next = '0;
        carry_next  = 1'b0;
        is_add_sub  = 1'b0;
        op_valid    = 1'b1;
        case (op)
            OP_ADD, OP_SUB: begin
                result_next = sum;
                is_add_sub  = 1'b1;
            end
            OP_MUL: begin
                result_next = product;
                carry_next  = product_carry;    // High byte nonzero
            end
            OP_DIV: begin
                result_next = quotient;
                carry_next  = divide_by_zero;   // Zero divisor marks C
            end
            OP_MOD: begin
                result_next = remainder;
                carry_next  = divide_by_zero;
            end
            OP_AND, OP_OR, OP_XOR, OP_NOT, OP_NOR, OP_NAND, OP_XNOR: begin
                result_next = bitwise_result;
            end
            default: op_valid = 1'b0;           // Invalid opcode, all zeros
        endcase
    end

    always_comb begin
        flags_next = '0;
        if (is_add_sub) begin
            flags_next = sum_flags;
        end else if (op_valid) begin
            flags_next[FLAG_Z] = (result_next == '0);
            flags_next[FLAG_S] = result_next[DATA_W-1];
            flags_next[FLAG_C] = carry_next;    // V stays 0 here
        end
    end

    // Second pipeline register, result and flags share the cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else begin
            result <= result_next;
            flags  <= flags_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/shift_add_multiplier.sv
`default_nettype none
`timescale 1ns/1ns

module shift_add_multiplier #(
    parameter int DATA_W = 8
) (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] product,
    output logic              product_carry
);

    logic [2*DATA_W-1:0] a_wide;            // a zero-extended to product width
    logic [2*DATA_W-1:0] acc;               // Full double-width product

    assign a_wide = {{DATA_W{1'b0}}, a};

    // Unrolled loop, one partial product per bit of b
    always_comb begin
        acc = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (b[i]) begin
                acc = acc + (a_wide << i);  // a shifted to weight of bit i
            end
        end
    end

    assign product       = acc[DATA_W-1:0];             // Low half only
    assign product_carry = |acc[2*DATA_W-1:DATA_W];     // Upper half lost

endmodule

`default_nettype wire

// File: src.f
logic/alu_pkg.sv
logic/issue_stage.sv
logic/add_sub_unit.sv
logic/shift_add_multiplier.sv
logic/restoring_divider.sv
logic/bitwise_unit.sv
logic/result_stage.sv
logic/alu_processor.sv
testbench/tb_alu_processor.sv

// File: testbench/tb_alu_processor.sv
`default_nettype none
`timescale 1ns/1ns

module tb_alu_processor;
    import alu_pkg::*;

    localparam int DATA_W     = 8;
    localparam int MAX_CYCLES = 2000;       // Tests take a few hundred cycles

    logic               clk;
    logic               reset;
    logic [7:0]         opcode;
    logic [DATA_W-1:0]  operand_a;
    logic [DATA_W-1:0]  operand_b;
    logic [DATA_W-1:0]  result;
    logic [FLAGS_W-1:0] flags;

    logic [31:0]        lcg_state = 32'h775b9266;
    int                 cycles    = 0;

    // Expected outputs, two instructions in flight
    string              name_q[$];
    logic [DATA_W-1:0]  res_q[$];
    logic [FLAGS_W-1:0] flg_q[$];

    alu_processor #(.DATA_W(DATA_W)) dut0 (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (result),
        .flags     (flags)
    );

    always #2 clk = ~clk;                   // 4 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "stopping at first failure");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] rand_operand();
        logic [31:0] word;
        word = next_rand();
        return word[31 -: DATA_W];          // Upper bits are the better ones
    endfunction

    // Reference model of the ALU rules
    function automatic void predict(input logic [7:0] opc, input logic [DATA_W-1:0] x,
                                    input logic [DATA_W-1:0] y,
                                    output logic [DATA_W-1:0] r,
                                    output logic [FLAGS_W-1:0] f);
        logic [DATA_W:0]     wide;
        logic [2*DATA_W-1:0] prod;
        logic                op_ok;
        r     = '0;
        f     = '0;
        wide  = '0;
        prod  = '0;
        op_ok = 1'b1;
        case (opc)
            OPC_ADD: begin
                wide      = {1'b0, x} + {1'b0, y};
                r         = wide[DATA_W-1:0];
                f[FLAG_C] = wide[DATA_W];
                f[FLAG_V] = (x[DATA_W-1] == y[DATA_W-1]) && (r[DATA_W-1] != x[DATA_W-1]);
            end
            OPC_SUB: begin
                r         = x - y;
                f[FLAG_C] = (x >= y);               // No borrow
                f[FLAG_V] = (x[DATA_W-1] != y[DATA_W-1]) && (r[DATA_W-1] != x[DATA_W-1]);
            end
            OPC_MUL: begin
                prod      = {{DATA_W{1'b0}}, x} * {{DATA_W{1'b0}}, y};
                r         = prod[DATA_W-1:0];
                f[FLAG_C] = |prod[2*DATA_W-1:DATA_W];
            end
            OPC_DIV: begin
                r         = (y == '0) ? '0 : x / y;
                f[FLAG_C] = (y == '0);
            end
            OPC_MOD: begin
                r         = (y == '0) ? '0 : x % y;
                f[FLAG_C] = (y == '0);
            end
            OPC_AND:  r = x & y;
            OPC_OR:   r = x | y;
            OPC_XOR:  r = x ^ y;
            OPC_NOT:  r = ~x;
            OPC_NOR:  r = ~(x | y);
            OPC_NAND: r = ~(x & y);
            OPC_XNOR: r = ~(x ^ y);
            default:  op_ok = 1'b0;                 // Invalid, all zeros
        endcase
        if (op_ok) begin
            f[FLAG_Z] = (r == '0);
            f[FLAG_S] = r[DATA_W-1];
        end
    endfunction

    task automatic check_result(input string name, input logic [DATA_W-1:0] expected,
                                input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: result expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flags(input string name, input logic [FLAGS_W-1:0] expected,
                               input logic [FLAGS_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: flags (VCSZ) expected %b, actual %b", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // One cycle: check the instruction from two cycles back, then issue a new one
    task automatic step(input string name, input logic [7:0] opc,
                        input logic [DATA_W-1:0] x, input logic [DATA_W-1:0] y);
        string              exp_name;
        logic [DATA_W-1:0]  exp_res;
        logic [FLAGS_W-1:0] exp_flg;
        @(posedge clk);
        #1;                                 // Outputs settled after the edge
        if (res_q.size() >= 2) begin
            exp_name = name_q.pop_front();
            exp_res  = res_q.pop_front();
            exp_flg  = flg_q.pop_front();
            check_result(exp_name, exp_res, result);
            check_flags(exp_name, exp_flg, flags);
        end
        predict(opc, x, y, exp_res, exp_flg);
        name_q.push_back(name);
        res_q.push_back(exp_res);
        flg_q.push_back(exp_flg);
        opcode    = opc;
        operand_a = x;
        operand_b = y;
    endtask

    task automatic test_reset();
        reset = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_result("reset_held", '0, result);
            check_flags("reset_held", '0, flags);
        end
        reset = 1'b0;
        // Two slots already in the pipe, both must read zero
        repeat (2) begin
            name_q.push_back("after_reset");
            res_q.push_back('0);
            flg_q.push_back('0);
        end
    endtask

    task automatic test_add_sub();
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        step("add_7f_plus_1", OPC_ADD, 8'h7F, 8'h01);   // Signed overflow
        step("add_ff_plus_1", OPC_ADD, 8'hFF, 8'h01);   // Carry and zero
        step("sub_80_minus_1", OPC_SUB, 8'h80, 8'h01);
        step("sub_5_minus_5", OPC_SUB, 8'h05, 8'h05);
        step("sub_3_minus_7", OPC_SUB, 8'h03, 8'h07);   // Borrow
        for (int i = 0; i < 50; i++) begin
            x = rand_operand();
            y = rand_operand();
            step("add_random", OPC_ADD, x, y);
            step("sub_random", OPC_SUB, x, y);
        end
    endtask

    task automatic test_multiply();
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        step("mul_small", OPC_MUL, 8'h03, 8'h05);
        step("mul_zero", OPC_MUL, 8'h00, 8'h55);
        step("mul_one", OPC_MUL, 8'h01, 8'hAB);
        step("mul_10_by_10", OPC_MUL, 8'h10, 8'h10);    // Low byte 0, high byte set
        step("mul_ff_by_ff", OPC_MUL, 8'hFF, 8'hFF);
        for (int i = 0; i < 30; i++) begin
            x = rand_operand();
            y = rand_operand();
            step("mul_random", OPC_MUL, x, y);
        end
    endtask

    task automatic test_divide();
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        for (int i = 0; i < 30; i++) begin
            x = rand_operand();
            y = rand_operand();
            step("div_random", OPC_DIV, x, y);
            step("mod_random", OPC_MOD, x, y);
        end
        step("div_big_divisor", OPC_DIV, 8'h05, 8'hC8);
        step("mod_big_divisor", OPC_MOD, 8'h05, 8'hC8);
        step("div_by_zero", OPC_DIV, 8'h37, 8'h00);
        step("mod_by_zero", OPC_MOD, 8'h37, 8'h00);
        step("div_zero_by_zero", OPC_DIV, 8'h00, 8'h00);
    endtask

    task automatic test_bitwise_invalid();
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        for (int k = int'(OPC_AND); k <= int'(OPC_XNOR); k++) begin
            for (int i = 0; i < 10; i++) begin
                x = rand_operand();
                y = rand_operand();
                step("bitwise_random", 8'(k), x, y);
            end
        end
        step("xor_equal", OPC_XOR, 8'h5A, 8'h5A);        // Zero flag
        step("not_all_ones", OPC_NOT, 8'hFF, 8'h00);
        step("invalid_0", 8'h00, rand_operand(), rand_operand());
        step("invalid_13", 8'd13, rand_operand(), rand_operand());
        step("invalid_ff", 8'hFF, rand_operand(), rand_operand());
    endtask

    task automatic test_back_to_back();
        logic [7:0] opc;
        for (int i = 0; i < 100; i++) begin
            opc = 8'(next_rand() % 32'd12) + 8'd1;      // Valid opcodes 1 to 12
            step("back_to_back", opc, rand_operand(), rand_operand());
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        opcode    = 8'h00;
        operand_a = '0;
        operand_b = '0;
        test_reset();
        test_add_sub();
        test_multiply();
        test_divide();
        test_bitwise_invalid();
        test_back_to_back();
        step("flush", 8'h00, '0, '0);       // Drain the last two results
        step("flush", 8'h00, '0, '0);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
